//--- Bender.yml
package:
  name: link_rx

export_include_dirs:
  - .

sources:
  - files:
      - link_pkg.sv
      - uart_rx.sv
      - byte_fifo.sv
      - frame_decoder.sv
      - link_rx_top.sv
  - target: test
    files:
      - tb_link_rx.sv

//--- build.f
+incdir+.
link_pkg.sv
uart_rx.sv
byte_fifo.sv
frame_decoder.sv
link_rx_top.sv
tb_link_rx.sv

//--- byte_fifo.sv
/* Byte queue */

`timescale 1ns/100ps
`default_nettype none

`include "link_defs.svh"

module byte_fifo #(
    parameter int aw = `LINK_FIFO_AW
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             wr,
    input  wire link_pkg::byte_t wdata,
    input  wire             rd,
    output link_pkg::byte_t head,
    output logic            empty
);

    localparam int depth = 2 ** aw;

    link_pkg::byte_t mem [depth];
    logic [aw-1:0]   wptr;
    logic [aw-1:0]   rptr;
    logic [aw:0]     count;     // Occupancy, one bit wider than pointers
    logic            full;
    logic            do_wr;
    logic            do_rd;

    assign full  = (count == (aw + 1)'(depth));
    assign empty = (count == '0);
    assign do_wr = wr && !full;     // Overflow bytes are lost
    assign do_rd = rd && !empty;
    assign head  = mem[rptr];

    always_ff @(posedge clk) begin
        if (do_wr) mem[wptr] <= wdata;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Pointers and count
    always_ff @(posedge clk) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) wptr <= wptr + 1'b1;
            if (do_rd) rptr <= rptr + 1'b1;
            if (do_wr && !do_rd) count <= count + 1'b1;
            else if (do_rd && !do_wr) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- frame_decoder.sv
/* Link frame decoder */

`timescale 1ns/100ps
`default_nettype none

`include "link_defs.svh"

module frame_decoder (
    input  wire                     clk,
    input  wire                     rst,
    input  wire link_pkg::byte_t    head,
    input  wire                     empty,
    input  wire link_pkg::role_t    role,
    output logic                    rd,
    output link_pkg::peer_state_t   peer,
    output logic                    frame_seen
);

    link_pkg::link_frame_t frame;
    logic                  take;
    logic                  is_shooter;
    logic                  is_keeper;

    // Halves held until the upper half arrives
    link_pkg::payload_t keeper_lo;
    link_pkg::payload_t shot_x_lo;
    link_pkg::payload_t shot_x_hi;
    link_pkg::payload_t shot_y_lo;

    assign frame      = link_pkg::link_frame_t'(head);
    assign take       = !empty && !rd;      // rd high means this head is being popped
    assign is_shooter = (role == link_pkg::ROLE_SHOOTER);
    assign is_keeper  = (role == link_pkg::ROLE_KEEPER);

    // ~~~~~~~~~~~~~~~~~~~~
    // Pop handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            rd         <= 1'b0;
            frame_seen <= 1'b0;
        end else begin
            rd         <= take;
            frame_seen <= take;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Opcode decode
    always_ff @(posedge clk) begin
        if (rst) begin
            peer      <= '0;
            keeper_lo <= '0;
            shot_x_lo <= '0;
            shot_x_hi <= '0;
            shot_y_lo <= '0;
        end else if (take) begin
            case (frame.opcode)
                `OP_SYNC: begin
                    // Defaults cover unknown codes, which drop the link
                    peer.connected     <= 1'b0;
                    peer.peer_shooter  <= 1'b0;
                    peer.game_starts   <= 1'b0;
                    peer.back_to_start <= 1'b0;
                    case (frame.payload)
                        `SYNC_SHOOTER_START: begin
                            peer.connected    <= 1'b1;
                            peer.peer_shooter <= 1'b1;
                            peer.game_starts  <= 1'b1;
                        end
                        `SYNC_KEEPER_START: begin
                            peer.connected   <= 1'b1;
                            peer.game_starts <= 1'b1;
                        end
                        `SYNC_LINKED: peer.connected <= 1'b1;
                        `SYNC_BACK_TO_START: begin
                            peer.connected     <= 1'b1;
                            peer.back_to_start <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                `OP_KEEPER_LO: if (is_shooter) keeper_lo <= frame.payload;
                `OP_KEEPER_HI: begin
                    if (is_shooter) peer.keeper_pos <= {frame.payload, keeper_lo};
                end
                `OP_SHOT_X_LO: if (is_keeper) shot_x_lo <= frame.payload;
                `OP_SHOT_X_HI: if (is_keeper) shot_x_hi <= frame.payload;
                `OP_SHOT_Y_LO: if (is_keeper) shot_y_lo <= frame.payload;
                `OP_SHOT_Y_HI: begin
                    if (is_keeper) begin        // x and y land together
                        peer.shot_x <= {shot_x_hi, shot_x_lo};
                        peer.shot_y <= {frame.payload, shot_y_lo};
                    end
                end
                `OP_SCORE: begin
                    if (is_shooter || is_keeper) begin
                        peer.peer_input  <= frame.payload[4];    // Byte bit 7
                        peer.peer_scored <= frame.payload[3];    // Byte bit 6
                        peer.peer_score  <= frame.payload[2:0];
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- link_defs.svh
/* Link receive definitions */

`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Serial timing and queue size
`define LINK_CLKS_PER_BIT 16
`define LINK_FIFO_AW      2     // 4 entries

// ~~~~~~~~~~~~~~~~~~~~
// Frame opcodes, low 3 bits of each byte
`define OP_SYNC      3'd0
`define OP_KEEPER_LO 3'd1
`define OP_KEEPER_HI 3'd2
`define OP_SHOT_X_LO 3'd3
`define OP_SHOT_X_HI 3'd4
`define OP_SHOT_Y_LO 3'd5
`define OP_SHOT_Y_HI 3'd6
`define OP_SCORE     3'd7

// Sync payload codes
`define SYNC_SHOOTER_START 5'b11001
`define SYNC_KEEPER_START  5'b01001
`define SYNC_LINKED        5'b00001
`define SYNC_BACK_TO_START 5'b00101

`endif

//--- link_pkg.sv
/* Link receive types */

`default_nettype none

package link_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Plain vectors
    typedef logic [7:0] byte_t;
    typedef logic [2:0] opcode_t;
    typedef logic [4:0] payload_t;
    typedef logic [9:0] coord_t;     // Screen coordinate
    typedef logic [2:0] score_t;     // Goal count

    // Local game role
    typedef enum logic [1:0] {
        ROLE_START,
        ROLE_SHOOTER,
        ROLE_KEEPER,
        ROLE_END
    } role_t;

    // One byte on the wire, payload on top
    typedef struct packed {
        payload_t payload;
        opcode_t  opcode;
    } link_frame_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // What the peer board has told us
    typedef struct packed {
        logic   connected;
        logic   peer_shooter;
        logic   game_starts;
        logic   back_to_start;
        coord_t keeper_pos;
        coord_t shot_x;
        coord_t shot_y;
        logic   peer_input;
        logic   peer_scored;
        score_t peer_score;
    } peer_state_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

//--- link_rx_top.sv
/* Link receive path */

`timescale 1ns/100ps
`default_nettype none

`include "link_defs.svh"

module link_rx_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     rx,
    input  wire link_pkg::role_t    role,
    output link_pkg::peer_state_t   peer,
    output logic                    frame_seen
);

    logic            byte_valid;
    link_pkg::byte_t byte_data;
    link_pkg::byte_t fifo_head;
    logic            fifo_empty;
    logic            fifo_rd;

    // ~~~~~~~~~~~~~~~~~~~~
    // Serial line to queue to decoder
    uart_rx #(.clks_per_bit(`LINK_CLKS_PER_BIT)) u_uart_rx (
        .clk, .rst, .rx,
        .byte_valid, .byte_data
    );

    byte_fifo #(.aw(`LINK_FIFO_AW)) u_byte_fifo (
        .clk, .rst,
        .wr(byte_valid), .wdata(byte_data),
        .rd(fifo_rd), .head(fifo_head), .empty(fifo_empty)
    );

    frame_decoder u_frame_decoder (
        .clk, .rst,
        .head(fifo_head), .empty(fifo_empty), .role,
        .rd(fifo_rd), .peer, .frame_seen
    );

endmodule

`default_nettype wire

//--- tb_link_rx.sv
/* Link receive testbench */

`timescale 1ns/100ps
`default_nettype none

`include "link_defs.svh"

module tb_link_rx;

    logic                  clk;
    logic                  rst;
    logic                  rx;
    link_pkg::role_t       role;
    link_pkg::peer_state_t peer;
    logic                  frame_seen;

    link_pkg::peer_state_t exp;             // Model of the peer state
    link_pkg::payload_t    m_keeper_lo;
    link_pkg::payload_t    m_x_lo;
    link_pkg::payload_t    m_x_hi;
    link_pkg::payload_t    m_y_lo;
    logic [31:0]           rng;
    int                    sent;
    int                    seen;
    int                    errors;
    int                    tests;

    link_rx_top DUT (
        .clk, .rst, .rx, .role,
        .peer, .frame_seen
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Count decoded bytes
    always @(posedge clk) begin
        if (!rst && frame_seen) seen <= seen + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic link_pkg::coord_t next_coord();
        rng = xorshift(rng);
        return rng[9:0];
    endfunction

    task automatic check_peer(input link_pkg::peer_state_t got,
                              input link_pkg::peer_state_t want, input string msg);
        if (got !== want) begin
            $display("FAIL %0t: %s peer %h expected %h", $time, msg, got, want);
            errors++;
        end
    endtask

    task automatic check_coord(input link_pkg::coord_t got,
                               input link_pkg::coord_t want, input string msg);
        if (got !== want) begin
            $display("FAIL %0t: %s coord %0d expected %0d", $time, msg, got, want);
            errors++;
        end
    endtask

    task automatic check_score(input link_pkg::score_t got,
                               input link_pkg::score_t want, input string msg);
        if (got !== want) begin
            $display("FAIL %0t: %s score %0d expected %0d", $time, msg, got, want);
            errors++;
        end
    endtask

    // Decoder rules applied to the expected state
    task automatic apply_model(input link_pkg::byte_t b);
        link_pkg::payload_t p;
        logic               playing;
        p = b[7:3];
        playing = (role == link_pkg::ROLE_SHOOTER) || (role == link_pkg::ROLE_KEEPER);
        case (b[2:0])
            `OP_SYNC: begin
                exp.connected     = (p == `SYNC_SHOOTER_START) || (p == `SYNC_KEEPER_START)
                                    || (p == `SYNC_LINKED) || (p == `SYNC_BACK_TO_START);
                exp.peer_shooter  = (p == `SYNC_SHOOTER_START);
                exp.game_starts   = (p == `SYNC_SHOOTER_START) || (p == `SYNC_KEEPER_START);
                exp.back_to_start = (p == `SYNC_BACK_TO_START);
            end
            `OP_KEEPER_LO: if (role == link_pkg::ROLE_SHOOTER) m_keeper_lo = p;
            `OP_KEEPER_HI: if (role == link_pkg::ROLE_SHOOTER) exp.keeper_pos = {p, m_keeper_lo};
            `OP_SHOT_X_LO: if (role == link_pkg::ROLE_KEEPER) m_x_lo = p;
            `OP_SHOT_X_HI: if (role == link_pkg::ROLE_KEEPER) m_x_hi = p;
            `OP_SHOT_Y_LO: if (role == link_pkg::ROLE_KEEPER) m_y_lo = p;
            `OP_SHOT_Y_HI: begin
                if (role == link_pkg::ROLE_KEEPER) begin
                    exp.shot_x = {m_x_hi, m_x_lo};
                    exp.shot_y = {p, m_y_lo};
                end
            end
            default: begin
                if (playing) begin
                    exp.peer_input  = b[7];
                    exp.peer_scored = b[6];
                    exp.peer_score  = b[5:3];
                end
            end
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Serial driver, called and left on a falling edge
    task automatic send_byte(input link_pkg::byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};     // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            repeat (`LINK_CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic send_frame(input link_pkg::opcode_t op, input link_pkg::payload_t pl);
        apply_model({pl, op});
        send_byte({pl, op});
        sent++;
    endtask

    // Every sent byte must come out as a frame_seen strobe
    task automatic wait_frame();
        int n;
        n = 0;
        while (seen < sent) begin
            @(negedge clk);
            n++;
            if (n > 40 * `LINK_CLKS_PER_BIT) begin
                $display("Timed out waiting for frame_seen, %0d of %0d bytes decoded",
                         seen, sent);
                $display("tests failed");
                $finish;
            end
        end
        if (seen != sent) begin
            $display("FAIL %0t: %0d frame_seen strobes for %0d bytes sent", $time, seen, sent);
            errors++;
        end
    endtask

    // One frame, then the whole state against the model
    task automatic send_and_check(input link_pkg::opcode_t op, input link_pkg::payload_t pl,
                                  input string msg);
        send_frame(op, pl);
        wait_frame();
        check_peer(peer, exp, msg);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    task automatic sync_test();
        int e;
        e = errors;
        check_peer(peer, '0, "after reset");
        send_and_check(`OP_SYNC, `SYNC_SHOOTER_START, "shooter start");
        send_and_check(`OP_SYNC, `SYNC_KEEPER_START, "keeper start");
        send_and_check(`OP_SYNC, `SYNC_LINKED, "linked");
        send_and_check(`OP_SYNC, `SYNC_BACK_TO_START, "back to start");
        send_and_check(`OP_SYNC, 5'b10110, "unknown sync");
        end_test("sync codes", e);
    endtask

    task automatic keeper_test();
        int               e;
        link_pkg::coord_t c;
        e = errors;
        role = link_pkg::ROLE_SHOOTER;
        c = next_coord();
        send_frame(`OP_KEEPER_LO, c[4:0]);
        wait_frame();
        check_coord(peer.keeper_pos, exp.keeper_pos, "keeper low only");
        send_frame(`OP_KEEPER_HI, c[9:5]);
        wait_frame();
        check_coord(peer.keeper_pos, c, "keeper position");
        end_test("keeper position", e);
    endtask

    task automatic shot_test();
        int               e;
        link_pkg::coord_t x;
        link_pkg::coord_t y;
        e = errors;
        role = link_pkg::ROLE_KEEPER;
        x = next_coord();
        y = next_coord();
        send_and_check(`OP_SHOT_X_LO, x[4:0], "shot x low");
        send_and_check(`OP_SHOT_X_HI, x[9:5], "shot x high");
        send_and_check(`OP_SHOT_Y_LO, y[4:0], "shot y low");
        send_frame(`OP_SHOT_Y_HI, y[9:5]);
        wait_frame();
        check_coord(peer.shot_x, x, "shot x");
        check_coord(peer.shot_y, y, "shot y");
        end_test("shot position", e);
    endtask

    task automatic gating_test();
        int e;
        e = errors;
        role = link_pkg::ROLE_SHOOTER;     // Shot frames belong to the keeper role
        for (int op = 3; op <= 6; op++) send_frame(3'(op), 5'h1f);
        role = link_pkg::ROLE_KEEPER;
        send_frame(`OP_KEEPER_LO, 5'h15);
        send_frame(`OP_KEEPER_HI, 5'h0a);
        role = link_pkg::ROLE_START;
        send_frame(`OP_SCORE, 5'h1f);
        wait_frame();
        check_peer(peer, exp, "gated frames");
        end_test("role gating", e);
    endtask

    task automatic score_test();
        int              e;
        link_pkg::byte_t b;
        e = errors;
        role = link_pkg::ROLE_SHOOTER;
        b = 8'(next_coord());
        send_frame(`OP_SCORE, b[7:3]);
        wait_frame();
        check_score(peer.peer_score, b[5:3], "score as shooter");
        check_peer(peer, exp, "score flags as shooter");
        role = link_pkg::ROLE_KEEPER;
        b = ~b;
        send_frame(`OP_SCORE, b[7:3]);
        wait_frame();
        check_score(peer.peer_score, b[5:3], "score as keeper");
        check_peer(peer, exp, "score flags as keeper");
        end_test("score", e);
    endtask

    task automatic burst_test();
        int               e;
        link_pkg::coord_t x;
        link_pkg::coord_t y;
        e = errors;
        role = link_pkg::ROLE_KEEPER;
        x = next_coord();
        y = next_coord();
        send_frame(`OP_SYNC, `SYNC_KEEPER_START);  // No idle time between frames
        send_frame(`OP_SHOT_X_LO, x[4:0]);
        send_frame(`OP_SHOT_X_HI, x[9:5]);
        send_frame(`OP_SHOT_Y_LO, y[4:0]);
        send_frame(`OP_SHOT_Y_HI, y[9:5]);
        send_frame(`OP_SCORE, 5'b10011);
        wait_frame();
        check_peer(peer, exp, "back-to-back");
        end_test("back-to-back", e);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst = 1'b1;
        rx = 1'b1;
        role = link_pkg::ROLE_START;
        exp = '0;
        m_keeper_lo = '0;
        m_x_lo = '0;
        m_x_hi = '0;
        m_y_lo = '0;
        rng = 32'haad0;
        sent = 0;
        seen = 0;
        errors = 0;
        tests = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        sync_test();
        keeper_test();
        shot_test();
        gating_test();
        score_test();
        burst_test();
        $display("%0d tests run, %0d frames decoded, %0d errors", tests, seen, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
/* Serial byte receiver */

`timescale 1ns/100ps
`default_nettype none

`include "link_defs.svh"

module uart_rx #(
    parameter int clks_per_bit = `LINK_CLKS_PER_BIT
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rx,
    output logic                byte_valid,
    output link_pkg::byte_t     byte_data
);

    localparam int cw = $clog2(clks_per_bit);
    localparam int half_bit = clks_per_bit / 2;

    link_pkg::rx_state_t state;
    logic [cw-1:0]       cnt;       // Cycles within current bit
    logic [2:0]          bit_idx;   // Data bit being received
    link_pkg::byte_t     shreg;
    logic                bit_end;
    logic                half_end;

    assign bit_end  = (cnt == cw'(clks_per_bit - 1));
    assign half_end = (cnt == cw'(half_bit - 1));

    // ~~~~~~~~~~~~~~~~~~~~
    // Bit timing FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= link_pkg::RX_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                link_pkg::RX_IDLE: begin
                    cnt <= '0;
                    if (!rx) state <= link_pkg::RX_START;   // Falling edge of start bit
                end
                link_pkg::RX_START: begin
                    if (half_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // Line back high at mid start bit, treat as a glitch
                        state   <= rx ? link_pkg::RX_IDLE : link_pkg::RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                link_pkg::RX_DATA: begin
                    if (bit_end) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) state <= link_pkg::RX_STOP;
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                link_pkg::RX_STOP: begin
                    if (bit_end) begin
                        cnt        <= '0;
                        byte_valid <= rx;   // Framing error drops the byte
                        state      <= link_pkg::RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= link_pkg::RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == link_pkg::RX_DATA && bit_end) shreg <= {rx, shreg[7:1]};
    end

    assign byte_data = shreg;

endmodule

`default_nettype wire
